/* rtl/cpuPkg.sv */
// Accumulator CPU shared widths, opcodes, select codes and instruction word layout
`default_nettype none

package cpuPkg;

    localparam int DataWidth    = 16;
    localparam int AddrWidth    = 6;
    localparam int RegAddrWidth = 3;
    localparam int SelWidth     = 2;
    localparam int StateWidth   = 4;

    // First instruction address after reset
    localparam logic [AddrWidth-1:0] ResetPc = 6'd8;

    localparam logic [3:0] OpMov  = 4'd0;
    localparam logic [3:0] OpAdd  = 4'd1;
    localparam logic [3:0] OpSub  = 4'd2;
    localparam logic [3:0] OpMul  = 4'd3;
    localparam logic [3:0] OpDiv  = 4'd4;
    localparam logic [3:0] OpIn   = 4'd7;
    localparam logic [3:0] OpOut  = 4'd8;
    localparam logic [3:0] OpStop = 4'd15;

    // Low nibble of a MOV that carries a second immediate word
    localparam logic [3:0] ImmIndicator = 4'd8;

    // Accumulator sources
    localparam logic [SelWidth-1:0] AccMem = 2'd0;
    localparam logic [SelWidth-1:0] AccIn  = 2'd1;
    localparam logic [SelWidth-1:0] AccAlu = 2'd2;
    localparam logic [SelWidth-1:0] AccImm = 2'd3;

    // MAR sources
    localparam logic [SelWidth-1:0] MarPc      = 2'd0;
    localparam logic [SelWidth-1:0] MarOperand = 2'd1;
    localparam logic [SelWidth-1:0] MarMem     = 2'd2;

    // Output register sources
    localparam logic [SelWidth-1:0] OutAcc = 2'd0;
    localparam logic [SelWidth-1:0] OutTmp = 2'd1;
    localparam logic [SelWidth-1:0] OutMem = 2'd2;

    // Control FSM states
    localparam logic [StateWidth-1:0] StReset     = 4'd0;
    localparam logic [StateWidth-1:0] StLoadPc    = 4'd1;
    localparam logic [StateWidth-1:0] StFetch0    = 4'd2;
    localparam logic [StateWidth-1:0] StFetch1    = 4'd3;
    localparam logic [StateWidth-1:0] StFetch2    = 4'd4;
    localparam logic [StateWidth-1:0] StDecode    = 4'd5;
    localparam logic [StateWidth-1:0] StIndirect  = 4'd6;
    localparam logic [StateWidth-1:0] StExecute   = 4'd7;
    localparam logic [StateWidth-1:0] StDestPtr   = 4'd8;
    localparam logic [StateWidth-1:0] StWrite     = 4'd9;
    localparam logic [StateWidth-1:0] StStopEmit1 = 4'd10;
    localparam logic [StateWidth-1:0] StStopEmit2 = 4'd11;
    localparam logic [StateWidth-1:0] StSpin      = 4'd12;

    // One instruction word, seen as three operands or as an immediate MOV header
    typedef union packed {
        struct packed {
            logic [3:0]              opcode;
            logic                    op0Mode;
            logic [RegAddrWidth-1:0] op0Addr;
            logic                    op1Mode;
            logic [RegAddrWidth-1:0] op1Addr;
            logic                    op2Mode;
            logic [RegAddrWidth-1:0] op2Addr;
        } ops;
        struct packed {
            logic [3:0] opcode;
            logic [7:0] unused;
            logic [3:0] immInd;
        } imm;
    } instrWordT;

endpackage

`default_nettype wire

/* rtl/alu.sv */
// Combinational ALU doing unsigned add, subtract, multiply and divide on data words
`default_nettype none

module alu (
    input  logic [1:0]                   op,
    input  logic [cpuPkg::DataWidth-1:0] a,
    input  logic [cpuPkg::DataWidth-1:0] b,
    output logic [cpuPkg::DataWidth-1:0] result
);

    // Op code is the instruction opcode minus one
    always_comb begin
        case (op)
            2'd0: begin
                result = a + b;
            end
            2'd1: begin
                result = a - b;
            end
            2'd2: begin
                // Product wraps to the low data word
                result = a * b;
            end
            default: begin
                // Divide by zero yields zero
                if (b == '0) begin
                    result = '0;
                end else begin
                    result = a / b;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/datapath.sv */
// CPU datapath with PC, MAR, MDR, accumulator, TMP1, output register and the ALU
`default_nettype none

module datapath (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              ldPc,
    input  logic                              incPc,
    input  logic                              ldMar,
    input  logic [cpuPkg::SelWidth-1:0]       marSel,
    input  logic [cpuPkg::RegAddrWidth-1:0]   operandAddr,
    input  logic                              ldMdr,
    input  logic                              mdrFromAlu,
    input  logic                              ldAcc,
    input  logic [cpuPkg::SelWidth-1:0]       accSel,
    input  logic [cpuPkg::DataWidth-1:0]      immWord,
    input  logic                              ldTmp,
    input  logic                              ldOut,
    input  logic [cpuPkg::SelWidth-1:0]       outSel,
    input  logic [1:0]                        aluOp,
    input  logic [cpuPkg::DataWidth-1:0]      memIn,
    input  logic [cpuPkg::DataWidth-1:0]      inData,
    output logic [cpuPkg::AddrWidth-1:0]      pc,
    output logic [cpuPkg::AddrWidth-1:0]      memAddr,
    output logic [cpuPkg::DataWidth-1:0]      memData,
    output logic [cpuPkg::DataWidth-1:0]      outData,
    output logic                              outValid
);

    logic [cpuPkg::DataWidth-1:0] acc;
    logic [cpuPkg::DataWidth-1:0] tmp1;
    logic [cpuPkg::DataWidth-1:0] aluResult;
    logic [cpuPkg::DataWidth-1:0] accNext;
    logic [cpuPkg::DataWidth-1:0] outNext;
    logic [cpuPkg::AddrWidth-1:0] marNext;

    // Second operand always comes straight from memory
    alu i_alu (
        .op     (aluOp),
        .a      (acc),
        .b      (memIn),
        .result (aluResult)
    );

    always_comb begin
        case (marSel)
            cpuPkg::MarOperand: marNext = {{(cpuPkg::AddrWidth-cpuPkg::RegAddrWidth){1'b0}},
                                           operandAddr};
            cpuPkg::MarMem:     marNext = memIn[cpuPkg::AddrWidth-1:0];
            default:            marNext = pc;
        endcase
    end

    always_comb begin
        case (accSel)
            cpuPkg::AccIn:  accNext = inData;
            cpuPkg::AccAlu: accNext = aluResult;
            cpuPkg::AccImm: accNext = immWord;
            default:        accNext = memIn;
        endcase
    end

    always_comb begin
        case (outSel)
            cpuPkg::OutTmp: outNext = tmp1;
            cpuPkg::OutMem: outNext = memIn;
            default:        outNext = acc;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (ldPc) begin
            pc <= cpuPkg::ResetPc;
        end else if (incPc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ldMar) begin
            memAddr <= marNext;
        end
        if (ldMdr) begin
            memData <= mdrFromAlu ? aluResult : acc;
        end
        if (ldAcc) begin
            acc <= accNext;
        end
        if (ldTmp) begin
            tmp1 <= memIn;
        end
    end

    // Valid strobe marks each new output value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outData  <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= ldOut;
            if (ldOut) begin
                outData <= outNext;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
// Control unit with instruction register, multicycle FSM, operand walk and input handshake
`default_nettype none

module controlUnit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [cpuPkg::DataWidth-1:0]      memIn,
    input  logic                              inAck,
    output logic                              ldPc,
    output logic                              incPc,
    output logic                              ldMar,
    output logic [cpuPkg::SelWidth-1:0]       marSel,
    output logic [cpuPkg::RegAddrWidth-1:0]   operandAddr,
    output logic                              ldMdr,
    output logic                              mdrFromAlu,
    output logic                              ldAcc,
    output logic [cpuPkg::SelWidth-1:0]       accSel,
    output logic [cpuPkg::DataWidth-1:0]      immWord,
    output logic                              ldTmp,
    output logic                              ldOut,
    output logic [cpuPkg::SelWidth-1:0]       outSel,
    output logic [1:0]                        aluOp,
    output logic                              memWe,
    output logic                              inReq,
    output logic                              halted
);

    logic [cpuPkg::StateWidth-1:0]   state;
    logic [cpuPkg::StateWidth-1:0]   stateNext;
    logic [1:0]                      cnt;
    logic [1:0]                      cntNext;
    logic                            inReqNext;
    cpuPkg::instrWordT               ir;
    cpuPkg::instrWordT               fetched;
    logic                            ldIr;
    logic                            ldImm;
    logic [cpuPkg::RegAddrWidth-1:0] slotAddr [3];
    logic [2:0]                      slotMode;
    logic [2:0]                      needMask;
    logic                            slotFound;
    logic [1:0]                      nextSlot;
    logic                            isAlu;
    logic                            emitStop;

    function automatic logic immMov(input cpuPkg::instrWordT w);
        return (w.imm.opcode == cpuPkg::OpMov) && (w.imm.immInd == cpuPkg::ImmIndicator);
    endfunction

    assign fetched = memIn;
    assign slotAddr[0] = ir.ops.op0Addr;
    assign slotAddr[1] = ir.ops.op1Addr;
    assign slotAddr[2] = ir.ops.op2Addr;
    assign slotMode = {ir.ops.op2Mode, ir.ops.op1Mode, ir.ops.op0Mode};
    assign isAlu = (ir.ops.opcode >= cpuPkg::OpAdd) && (ir.ops.opcode <= cpuPkg::OpDiv);
    assign halted = (state == cpuPkg::StSpin);

    // Opcode minus one, DIV wraps to 3
    assign aluOp = ir.ops.opcode[1:0] - 2'd1;

    // Source operands each opcode reads, STOP only its nonzero ones
    always_comb begin
        case (ir.ops.opcode)
            cpuPkg::OpMov:  needMask = immMov(ir) ? 3'b000 : 3'b010;
            cpuPkg::OpAdd,
            cpuPkg::OpSub,
            cpuPkg::OpMul,
            cpuPkg::OpDiv:  needMask = 3'b110;
            cpuPkg::OpOut:  needMask = 3'b001;
            cpuPkg::OpStop: needMask = {slotAddr[2] != '0, slotAddr[1] != '0, slotAddr[0] != '0};
            default:        needMask = 3'b000;
        endcase
    end

    // Lowest needed slot not yet requested
    always_comb begin
        slotFound = 1'b0;
        nextSlot  = 2'd0;
        for (int s = 2; s >= 0; s--) begin
            if (needMask[s] && (s >= int'(cnt))) begin
                slotFound = 1'b1;
                nextSlot  = 2'(s);
            end
        end
    end

    always_comb begin
        stateNext   = state;
        cntNext     = cnt;
        inReqNext   = inReq;
        ldPc        = 1'b0;
        incPc       = 1'b0;
        ldMar       = 1'b0;
        marSel      = cpuPkg::MarPc;
        operandAddr = slotAddr[0];
        ldMdr       = 1'b0;
        mdrFromAlu  = 1'b0;
        ldAcc       = 1'b0;
        accSel      = cpuPkg::AccMem;
        ldTmp       = 1'b0;
        ldOut       = 1'b0;
        outSel      = cpuPkg::OutAcc;
        memWe       = 1'b0;
        ldIr        = 1'b0;
        ldImm       = 1'b0;
        emitStop    = 1'b0;

        case (state)
            cpuPkg::StReset: begin
                stateNext = cpuPkg::StLoadPc;
            end
            cpuPkg::StLoadPc: begin
                ldPc      = 1'b1;
                stateNext = cpuPkg::StFetch0;
            end
            cpuPkg::StFetch0: begin
                ldMar     = 1'b1;
                incPc     = 1'b1;
                stateNext = cpuPkg::StFetch1;
            end
            cpuPkg::StFetch1: begin
                ldIr      = 1'b1;
                stateNext = cpuPkg::StDecode;
                if (immMov(fetched)) begin
                    ldMar     = 1'b1;
                    incPc     = 1'b1;
                    stateNext = cpuPkg::StFetch2;
                end
            end
            cpuPkg::StFetch2: begin
                ldImm     = 1'b1;
                stateNext = cpuPkg::StDecode;
            end
            cpuPkg::StDecode: begin
                if (ir.ops.opcode == cpuPkg::OpIn) begin
                    // Hold the request until acknowledged
                    inReqNext = 1'b1;
                    if (inReq && inAck) begin
                        ldAcc     = 1'b1;
                        accSel    = cpuPkg::AccIn;
                        inReqNext = 1'b0;
                        stateNext = cpuPkg::StExecute;
                    end
                end else begin
                    if (immMov(ir)) begin
                        ldAcc  = 1'b1;
                        accSel = cpuPkg::AccImm;
                    end
                    // Slot cnt-1 is on memIn, slot 2 stays there for execute
                    if (cnt == 2'd2 && ir.ops.opcode == cpuPkg::OpStop) begin
                        ldTmp = 1'b1;
                    end else if (cnt == 2'd1 || cnt == 2'd2) begin
                        ldAcc = 1'b1;
                    end
                    if (slotFound) begin
                        ldMar       = 1'b1;
                        marSel      = cpuPkg::MarOperand;
                        operandAddr = slotAddr[nextSlot];
                        cntNext     = nextSlot + 2'd1;
                        stateNext   = slotMode[nextSlot] ? cpuPkg::StIndirect
                                                         : cpuPkg::StDecode;
                    end else begin
                        cntNext   = 2'd0;
                        stateNext = cpuPkg::StExecute;
                    end
                end
            end
            cpuPkg::StIndirect: begin
                ldMar     = 1'b1;
                marSel    = cpuPkg::MarMem;
                stateNext = cpuPkg::StDecode;
            end
            cpuPkg::StExecute: begin
                case (ir.ops.opcode)
                    cpuPkg::OpMov, cpuPkg::OpIn,
                    cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpMul, cpuPkg::OpDiv: begin
                        // Destination address into MAR
                        ldMar  = 1'b1;
                        marSel = cpuPkg::MarOperand;
                        if (isAlu) begin
                            ldAcc  = 1'b1;
                            accSel = cpuPkg::AccAlu;
                        end
                        if (slotMode[0]) begin
                            stateNext = cpuPkg::StDestPtr;
                        end else begin
                            ldMdr      = 1'b1;
                            mdrFromAlu = isAlu;
                            stateNext  = cpuPkg::StWrite;
                        end
                    end
                    cpuPkg::OpOut: begin
                        ldOut     = 1'b1;
                        stateNext = cpuPkg::StFetch0;
                    end
                    cpuPkg::OpStop: begin
                        emitStop = 1'b1;
                    end
                    default: begin
                        stateNext = cpuPkg::StFetch0;
                    end
                endcase
            end
            cpuPkg::StDestPtr: begin
                // memIn holds the destination pointer
                ldMar     = 1'b1;
                marSel    = cpuPkg::MarMem;
                ldMdr     = 1'b1;
                stateNext = cpuPkg::StWrite;
            end
            cpuPkg::StWrite: begin
                memWe     = 1'b1;
                stateNext = cpuPkg::StFetch0;
            end
            cpuPkg::StStopEmit1, cpuPkg::StStopEmit2: begin
                emitStop = 1'b1;
            end
            cpuPkg::StSpin: begin
                stateNext = cpuPkg::StSpin;
            end
            default: begin
                stateNext = cpuPkg::StReset;
            end
        endcase

        // STOP emits remaining nonzero operands in order, one per cycle
        if (emitStop) begin
            stateNext = cpuPkg::StSpin;
            if (state == cpuPkg::StExecute && slotAddr[0] != '0) begin
                ldOut     = 1'b1;
                outSel    = cpuPkg::OutAcc;
                stateNext = cpuPkg::StStopEmit1;
            end else if (state != cpuPkg::StStopEmit2 && slotAddr[1] != '0) begin
                ldOut     = 1'b1;
                outSel    = cpuPkg::OutTmp;
                stateNext = cpuPkg::StStopEmit2;
            end else if (slotAddr[2] != '0) begin
                ldOut  = 1'b1;
                outSel = cpuPkg::OutMem;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpuPkg::StReset;
            cnt   <= 2'd0;
            inReq <= 1'b0;
        end else begin
            state <= stateNext;
            cnt   <= cntNext;
            inReq <= inReqNext;
        end
    end

    always_ff @(posedge clk) begin
        if (ldIr) begin
            ir <= fetched;
        end
        if (ldImm) begin
            immWord <= memIn;
        end
    end

endmodule

`default_nettype wire

/* rtl/cpuTop.sv */
// Accumulator CPU top level joining the control unit and the datapath
`default_nettype none

module cpuTop (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [cpuPkg::DataWidth-1:0] inData,
    input  logic                         inAck,
    input  logic [cpuPkg::DataWidth-1:0] memIn,
    output logic                         memWe,
    output logic [cpuPkg::AddrWidth-1:0] memAddr,
    output logic [cpuPkg::DataWidth-1:0] memData,
    output logic [cpuPkg::AddrWidth-1:0] pc,
    output logic [cpuPkg::DataWidth-1:0] outData,
    output logic                         outValid,
    output logic                         inReq,
    output logic                         halted
);

    logic                            ldPc;
    logic                            incPc;
    logic                            ldMar;
    logic [cpuPkg::SelWidth-1:0]     marSel;
    logic [cpuPkg::RegAddrWidth-1:0] operandAddr;
    logic                            ldMdr;
    logic                            mdrFromAlu;
    logic                            ldAcc;
    logic [cpuPkg::SelWidth-1:0]     accSel;
    logic [cpuPkg::DataWidth-1:0]    immWord;
    logic                            ldTmp;
    logic                            ldOut;
    logic [cpuPkg::SelWidth-1:0]     outSel;
    logic [1:0]                      aluOp;

    controlUnit i_controlUnit (
        .clk         (clk),
        .rst_n       (rst_n),
        .memIn       (memIn),
        .inAck       (inAck),
        .ldPc        (ldPc),
        .incPc       (incPc),
        .ldMar       (ldMar),
        .marSel      (marSel),
        .operandAddr (operandAddr),
        .ldMdr       (ldMdr),
        .mdrFromAlu  (mdrFromAlu),
        .ldAcc       (ldAcc),
        .accSel      (accSel),
        .immWord     (immWord),
        .ldTmp       (ldTmp),
        .ldOut       (ldOut),
        .outSel      (outSel),
        .aluOp       (aluOp),
        .memWe       (memWe),
        .inReq       (inReq),
        .halted      (halted)
    );

    datapath i_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .ldPc        (ldPc),
        .incPc       (incPc),
        .ldMar       (ldMar),
        .marSel      (marSel),
        .operandAddr (operandAddr),
        .ldMdr       (ldMdr),
        .mdrFromAlu  (mdrFromAlu),
        .ldAcc       (ldAcc),
        .accSel      (accSel),
        .immWord     (immWord),
        .ldTmp       (ldTmp),
        .ldOut       (ldOut),
        .outSel      (outSel),
        .aluOp       (aluOp),
        .memIn       (memIn),
        .inData      (inData),
        .pc          (pc),
        .memAddr     (memAddr),
        .memData     (memData),
        .outData     (outData),
        .outValid    (outValid)
    );

endmodule

`default_nettype wire

/* tests/memoryModel.sv */
// Testbench memory with asynchronous read, synchronous write and backdoor access
`default_nettype none

module memoryModel (
    input  logic                         clk,
    input  logic                         we,
    input  logic [cpuPkg::AddrWidth-1:0] addr,
    input  logic [cpuPkg::DataWidth-1:0] wdata,
    output logic [cpuPkg::DataWidth-1:0] rdata
);

    logic [cpuPkg::DataWidth-1:0] mem [2**cpuPkg::AddrWidth];

    // Read path is combinational from the address
    assign rdata = mem[addr];

    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Backdoor write used between program runs
    task automatic loadWord(
        input logic [cpuPkg::AddrWidth-1:0] a,
        input logic [cpuPkg::DataWidth-1:0] d
    );
        mem[a] = d;
    endtask

    function automatic logic [cpuPkg::DataWidth-1:0] peekWord(
        input logic [cpuPkg::AddrWidth-1:0] a
    );
        return mem[a];
    endfunction

endmodule

`default_nettype wire

/* tests/cpuTb.sv */
// Table-driven testbench running small programs on the accumulator CPU
`default_nettype none

module cpuTb;

    localparam int KindImmOut = 0;
    localparam int KindAlu    = 1;
    localparam int KindMovInd = 2;
    localparam int KindIn     = 3;
    localparam int KindStop   = 4;
    localparam int NumRows    = 10;
    localparam int RowBudget  = 200;
    localparam int MaxAckWait = 20;
    localparam int Seed       = 55567;

    // Pointer targets for the indirect MOV lie above the program area
    localparam logic [cpuPkg::AddrWidth-1:0] SrcTarget = 6'd40;
    localparam logic [cpuPkg::AddrWidth-1:0] DstTarget = 6'd50;

    typedef struct {
        int          kind;
        logic [3:0]  opc;
        logic [2:0]  d;
        logic [2:0]  s1;
        logic [2:0]  s2;
        logic [15:0] va;
        logic [15:0] vb;
        logic [15:0] vc;
        logic [15:0] expMem;
        int          nOut;
        logic [15:0] out0;
        logic [15:0] out1;
    } rowT;

    logic                         clk;
    logic                         rst_n;
    logic [cpuPkg::DataWidth-1:0] inData;
    logic                         inAck;
    logic [cpuPkg::DataWidth-1:0] memIn;
    logic                         memWe;
    logic [cpuPkg::AddrWidth-1:0] memAddr;
    logic [cpuPkg::DataWidth-1:0] memData;
    logic [cpuPkg::AddrWidth-1:0] pc;
    logic [cpuPkg::DataWidth-1:0] outData;
    logic                         outValid;
    logic                         inReq;
    logic                         halted;

    rowT                          rows [NumRows];
    logic [cpuPkg::DataWidth-1:0] outSeen [$];
    int                           weCount;
    int                           valueErrors;
    int                           otherErrors;
    int                           cycles;
    int                           cycleLimit;

    cpuTop i_cpuTop (
        .clk      (clk),
        .rst_n    (rst_n),
        .inData   (inData),
        .inAck    (inAck),
        .memIn    (memIn),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memData  (memData),
        .pc       (pc),
        .outData  (outData),
        .outValid (outValid),
        .inReq    (inReq),
        .halted   (halted)
    );

    memoryModel i_memoryModel (
        .clk   (clk),
        .we    (memWe),
        .addr  (memAddr),
        .wdata (memData),
        .rdata (memIn)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Output and write monitor
    always @(posedge clk) begin
        if (rst_n) begin
            if (outValid) begin
                outSeen.push_back(outData);
            end
            if (memWe) begin
                weCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic checkWord(input string name, input logic [cpuPkg::DataWidth-1:0] got,
                             input logic [cpuPkg::DataWidth-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkAddr(input string name, input logic [cpuPkg::AddrWidth-1:0] got,
                             input logic [cpuPkg::AddrWidth-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    // Instruction word in operand layout
    function automatic logic [15:0] encode(input logic [3:0] opc, input logic m0,
                                           input logic [2:0] a0, input logic m1,
                                           input logic [2:0] a1, input logic m2,
                                           input logic [2:0] a2);
        return {opc, m0, a0, m1, a1, m2, a2};
    endfunction

    task automatic loadMemory(input rowT r, output int progLen);
        logic [15:0] stopWord;
        stopWord = encode(cpuPkg::OpStop, 1'b0, 3'd0, 1'b0, 3'd0, 1'b0, 3'd0);
        for (int a = 0; a < 64; a++) begin
            i_memoryModel.loadWord(6'(a), {10'h2A5, 6'(a)});
        end
        case (r.kind)
            KindImmOut: begin
                i_memoryModel.loadWord(6'd8, encode(cpuPkg::OpMov, 1'b0, r.d, 1'b0, 3'd0,
                                                    1'b1, 3'd0));
                i_memoryModel.loadWord(6'd9, r.va);
                i_memoryModel.loadWord(6'd10, encode(cpuPkg::OpOut, 1'b0, r.d, 1'b0, 3'd0,
                                                     1'b0, 3'd0));
                i_memoryModel.loadWord(6'd11, stopWord);
                progLen = 4;
            end
            KindAlu: begin
                i_memoryModel.loadWord(6'(r.s1), r.va);
                i_memoryModel.loadWord(6'(r.s2), r.vb);
                i_memoryModel.loadWord(6'd8, encode(r.opc, 1'b0, r.d, 1'b0, r.s1,
                                                    1'b0, r.s2));
                i_memoryModel.loadWord(6'd9, stopWord);
                progLen = 2;
            end
            KindMovInd: begin
                i_memoryModel.loadWord(6'(r.s1), 16'(SrcTarget));
                i_memoryModel.loadWord(SrcTarget, r.va);
                i_memoryModel.loadWord(6'(r.d), 16'(DstTarget));
                i_memoryModel.loadWord(6'd8, encode(cpuPkg::OpMov, 1'b1, r.d, 1'b1, r.s1,
                                                    1'b0, 3'd0));
                i_memoryModel.loadWord(6'd9, stopWord);
                progLen = 2;
            end
            KindIn: begin
                i_memoryModel.loadWord(6'd8, encode(cpuPkg::OpIn, 1'b0, r.d, 1'b0, 3'd0,
                                                    1'b0, 3'd0));
                i_memoryModel.loadWord(6'd9, stopWord);
                progLen = 2;
            end
            default: begin
                i_memoryModel.loadWord(6'(r.d), r.va);
                i_memoryModel.loadWord(6'(r.s1), r.vb);
                i_memoryModel.loadWord(6'(r.s2), r.vc);
                i_memoryModel.loadWord(6'd8, encode(cpuPkg::OpStop, 1'b0, r.d, 1'b0, r.s1,
                                                    1'b0, r.s2));
                progLen = 1;
            end
        endcase
    endtask

    // IN handshake with a stray early acknowledge and a random delay
    task automatic serveInput(input rowT r);
        int delay;
        // Stray acknowledge spans reset, fetch and the first decode cycle
        inAck  <= 1'b1;
        inData <= 16'hDEAD;
        repeat (5) begin
            @(posedge clk);
            checkFlag("inReq", inReq, 1'b0);
        end
        inAck <= 1'b0;
        while (!inReq) begin
            @(posedge clk);
        end
        delay = $urandom_range(0, MaxAckWait);
        repeat (delay) begin
            @(posedge clk);
            checkFlag("inReq", inReq, 1'b1);
        end
        inAck  <= 1'b1;
        inData <= r.va;
        @(posedge clk);
        inAck  <= 1'b0;
        inData <= 16'hDEAD;
        @(posedge clk);
        checkFlag("inReq", inReq, 1'b0);
    endtask

    task automatic runRow(input int idx, input rowT r);
        int                           progLen;
        logic [cpuPkg::AddrWidth-1:0] pcHalt;
        @(posedge clk);
        rst_n <= 1'b0;
        inAck <= 1'b0;
        loadMemory(r, progLen);
        repeat (3) @(posedge clk);
        outSeen.delete();
        weCount = 0;
        rst_n <= 1'b1;
        if (r.kind == KindIn) begin
            serveInput(r);
        end
        while (!halted) begin
            @(posedge clk);
        end
        pcHalt = pc;
        checkAddr("pc", pcHalt, cpuPkg::ResetPc + 6'(progLen));
        repeat (10) begin
            @(posedge clk);
            checkAddr("pc", pc, pcHalt);
            checkFlag("halted", halted, 1'b1);
        end
        if (outSeen.size() != r.nOut) begin
            $display("Row %0d saw %0d outValid pulses but expected %0d",
                     idx, outSeen.size(), r.nOut);
            otherErrors++;
        end else begin
            if (r.nOut > 0) checkWord("outData", outSeen[0], r.out0);
            if (r.nOut > 1) checkWord("outData", outSeen[1], r.out1);
        end
        if (weCount != ((r.kind == KindStop) ? 0 : 1)) begin
            $display("Row %0d saw %0d memory writes, which is wrong", idx, weCount);
            otherErrors++;
        end
        if (r.kind == KindMovInd) begin
            checkWord("mem[DstTarget]", i_memoryModel.peekWord(DstTarget), r.expMem);
        end else if (r.kind != KindStop) begin
            checkWord($sformatf("mem[%0d]", r.d), i_memoryModel.peekWord(6'(r.d)), r.expMem);
        end
    endtask

    initial begin
        int inRows;
        cycles = 0;
        rst_n  = 1'b0;
        inAck  = 1'b0;
        inData = '0;
        valueErrors = 0;
        otherErrors = 0;
        void'($urandom(Seed));

        // kind, opc, d, s1, s2, va, vb, vc, expMem, nOut, out0, out1
        rows[0] = '{KindImmOut, cpuPkg::OpMov, 3'd3, 3'd0, 3'd0, 16'hBEEF, 16'h0, 16'h0,
                    16'hBEEF, 1, 16'hBEEF, 16'h0};
        rows[1] = '{KindAlu, cpuPkg::OpAdd, 3'd1, 3'd2, 3'd3, 16'hFFF0, 16'h0020, 16'h0,
                    16'h0010, 0, 16'h0, 16'h0};
        rows[2] = '{KindAlu, cpuPkg::OpSub, 3'd1, 3'd2, 3'd3, 16'h0005, 16'h0009, 16'h0,
                    16'hFFFC, 0, 16'h0, 16'h0};
        rows[3] = '{KindAlu, cpuPkg::OpMul, 3'd7, 3'd4, 3'd5, 16'h1234, 16'h0100, 16'h0,
                    16'h3400, 0, 16'h0, 16'h0};
        rows[4] = '{KindAlu, cpuPkg::OpDiv, 3'd6, 3'd2, 3'd3, 16'd100, 16'd7, 16'h0,
                    16'd14, 0, 16'h0, 16'h0};
        rows[5] = '{KindAlu, cpuPkg::OpDiv, 3'd6, 3'd2, 3'd3, 16'd5, 16'd0, 16'h0,
                    16'd0, 0, 16'h0, 16'h0};
        rows[6] = '{KindMovInd, cpuPkg::OpMov, 3'd4, 3'd5, 3'd0, 16'hA5A5, 16'h0, 16'h0,
                    16'hA5A5, 0, 16'h0, 16'h0};
        rows[7] = '{KindIn, cpuPkg::OpIn, 3'd6, 3'd0, 3'd0, 16'h7E57, 16'h0, 16'h0,
                    16'h7E57, 0, 16'h0, 16'h0};
        rows[8] = '{KindStop, cpuPkg::OpStop, 3'd3, 3'd0, 3'd6, 16'h1111, 16'h2222,
                    16'h3333, 16'h0, 2, 16'h1111, 16'h3333};
        rows[9] = '{KindStop, cpuPkg::OpStop, 3'd0, 3'd2, 3'd5, 16'h4444, 16'h5555,
                    16'h6666, 16'h0, 2, 16'h5555, 16'h6666};

        inRows = 0;
        foreach (rows[i]) begin
            if (rows[i].kind == KindIn) inRows++;
        end
        cycleLimit = NumRows * RowBudget + MaxAckWait * inRows;

        for (int i = 0; i < NumRows; i++) begin
            runRow(i, rows[i]);
        end

        $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
rtl/cpuPkg.sv
rtl/alu.sv
rtl/datapath.sv
rtl/controlUnit.sv
rtl/cpuTop.sv
tests/memoryModel.sv
tests/cpuTb.sv

/* Makefile */
# Verilator simulation of the accumulator CPU

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module cpuTb -f project.f -o cpuSim
	./obj_dir/cpuSim | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
